// File: lk_cfg_pkg.sv
// ============================================================
// board shell sizes and timing
// ============================================================
package lk_cfg_pkg;

    // data memory, addressed by the top switches swt[15:10]
    localparam int dm_addr_bits = 6;
    localparam int dm_words     = 1 << dm_addr_bits;

    // statistics counters
    localparam int cnt_bits = 32;

    // clocks per lit digit, tiny so a full scan fits in a short simulation
    localparam int scan_cnt_max = 4;

    // program ROM of the stepping core
    localparam int    prog_words = 64;
    localparam string prog_path  = "prog.hex";

endpackage

// File: lk_isa_pkg.sv
// ============================================================
// instruction set of the stepping core
// ============================================================
package lk_isa_pkg;

    localparam int word_bits = 16;

    // opcodes in instr[15:12]
    localparam logic [3:0] op_nop  = 4'h0;
    localparam logic [3:0] op_ldi  = 4'h1; // rd = sign extended imm
    localparam logic [3:0] op_add  = 4'h2; // rd = rd + rs
    localparam logic [3:0] op_ld   = 4'h3; // rd = mem[imm]
    localparam logic [3:0] op_st   = 4'h4; // mem[imm] = rd
    localparam logic [3:0] op_beqz = 4'h5; // if rd == 0, pc = pc + 1 + imm
    localparam logic [3:0] op_jmp  = 4'h6; // pc = imm
    localparam logic [3:0] op_disp = 4'h7; // display = rd
    localparam logic [3:0] op_halt = 4'h8;

    // field positions, rs and imm overlap since no opcode needs both
    localparam int op_hi  = 15;
    localparam int op_lo  = 12;
    localparam int rd_hi  = 11;
    localparam int rd_lo  = 9;
    localparam int rs_hi  = 8;
    localparam int rs_lo  = 6;
    localparam int imm_hi = 7;
    localparam int imm_lo = 0;

    // display source selection on swt[2:0]
    localparam logic [2:0] disp_core    = 3'd0;
    localparam logic [2:0] disp_cnt_cyc = 3'd1;
    localparam logic [2:0] disp_cnt_jmp = 3'd2;
    localparam logic [2:0] disp_cnt_bch = 3'd3;
    localparam logic [2:0] disp_cnt_bed = 3'd4;
    localparam logic [2:0] disp_cnt_nop = 3'd5;
    localparam logic [2:0] disp_pc      = 3'd6;
    localparam logic [2:0] disp_dm_dbg  = 3'd7;

endpackage

// File: run_control.sv
`timescale 1ns/1ps

module run_control (
    input  logic clk,
    input  logic rst_n,
    input  logic halt,
    input  logic resume,
    output logic run_en
);

    // the core comes out of reset running
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            run_en <= 1'b1;
        else if (halt)
            run_en <= 1'b0; // halt wins over a resume in the same cycle
        else if (resume)
            run_en <= 1'b1;
    end

    // a stopped core cannot retire its way into another HALT
    a_halt_running: assert property (@(posedge clk) disable iff (!rst_n)
        halt |-> run_en);

endmodule

// File: step_core.sv
`timescale 1ns/1ps

module step_core (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                run_en,
    input  logic                                core_gnt,
    input  logic [lk_isa_pkg::word_bits-1:0]    core_rdata,
    output logic                                core_req,
    output logic                                core_we,
    output logic [lk_cfg_pkg::dm_addr_bits-1:0] core_addr,
    output logic [lk_isa_pkg::word_bits-1:0]    core_wdata,
    output logic                                halt,
    output logic                                retire,
    output logic                                is_jump,
    output logic                                is_branch,
    output logic                                branched,
    output logic                                is_nop,
    output logic [lk_isa_pkg::word_bits-1:0]    pc,
    output logic [lk_isa_pkg::word_bits-1:0]    display
);
    import lk_cfg_pkg::*;
    import lk_isa_pkg::*;

    logic [word_bits-1:0] rom [prog_words];
    logic [word_bits-1:0] rf [8];
    logic [word_bits-1:0] instr;
    logic [word_bits-1:0] rd_val;
    logic [word_bits-1:0] rs_val;
    logic [word_bits-1:0] imm_sext;
    logic [word_bits-1:0] pc_inc;
    logic [3:0]           op;
    logic [2:0]           rd;
    logic [2:0]           rs;
    logic [7:0]           imm;
    logic                 ld_wait; // LD is in its capture cycle
    logic                 issue;

    initial $readmemh(prog_path, rom);

    assign instr    = rom[pc[$clog2(prog_words)-1:0]];
    assign op       = instr[op_hi:op_lo];
    assign rd       = instr[rd_hi:rd_lo];
    assign rs       = instr[rs_hi:rs_lo];
    assign imm      = instr[imm_hi:imm_lo];
    assign rd_val   = (rd == 3'd0) ? '0 : rf[rd]; // r0 reads as zero
    assign rs_val   = (rs == 3'd0) ? '0 : rf[rs];
    assign imm_sext = {{(word_bits-8){imm[7]}}, imm};
    assign pc_inc   = pc + 1'b1;

    assign issue      = run_en && !ld_wait;
    assign core_req   = issue && (op == op_ld || op == op_st);
    assign core_we    = issue && (op == op_st);
    assign core_addr  = imm[dm_addr_bits-1:0];
    assign core_wdata = rd_val;

    // LD finishes in its second cycle, everything else in the issue cycle
    assign retire    = ld_wait || (issue && op != op_ld);
    assign halt      = retire && (op == op_halt);
    assign is_jump   = retire && (op == op_jmp);
    assign is_branch = retire && (op == op_beqz);
    assign branched  = is_branch && (rd_val == '0);
    assign is_nop    = retire && (op == op_nop);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= '0;
            ld_wait <= 1'b0;
            display <= '0;
        end else begin
            ld_wait <= core_req && core_gnt && !core_we;
            if (retire) begin
                case (op)
                    op_jmp:  pc <= {{(word_bits-8){1'b0}}, imm};
                    op_beqz: pc <= (rd_val == '0) ? pc_inc + imm_sext : pc_inc;
                    default: pc <= pc_inc; // HALT also steps, so resume continues after it
                endcase
                if (op == op_disp)
                    display <= rd_val;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire && rd != 3'd0) begin
            case (op)
                op_ldi:  rf[rd] <= imm_sext;
                op_add:  rf[rd] <= rd_val + rs_val;
                op_ld:   rf[rd] <= core_rdata; // data from the request one cycle back
                default: ;
            endcase
        end
    end

    // run_en may only drop after HALT, never inside the two cycles of an LD
    a_retire_run: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(retire) |-> run_en);

    a_we_req: assert property (@(posedge clk) disable iff (!rst_n)
        core_we |-> core_req);

endmodule

// File: dm_arbiter.sv
`timescale 1ns/1ps

module dm_arbiter (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                core_req,
    input  logic                                core_we,
    input  logic [lk_cfg_pkg::dm_addr_bits-1:0] core_addr,
    input  logic [15:0]                         core_wdata,
    input  logic                                dbg_req,
    input  logic [lk_cfg_pkg::dm_addr_bits-1:0] dbg_addr,
    output logic                                core_gnt,
    output logic                                dbg_gnt,
    output logic                                mem_en,
    output logic                                mem_we,
    output logic [lk_cfg_pkg::dm_addr_bits-1:0] mem_addr,
    output logic [15:0]                         mem_wdata,
    output logic                                dbg_sel
);
    import lk_cfg_pkg::*;

    // core always wins, the debug reader takes the idle cycles
    assign core_gnt = core_req;
    assign dbg_gnt  = dbg_req && !core_req;

    assign mem_en    = core_gnt || dbg_gnt;
    assign mem_we    = core_gnt && core_we; // debug side only reads
    assign mem_addr  = core_gnt ? core_addr : dbg_addr;
    assign mem_wdata = core_wdata;

    // read data comes back one cycle later, so the owner is remembered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dbg_sel <= 1'b0;
        else
            dbg_sel <= dbg_gnt;
    end

    a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
        !(core_gnt && dbg_gnt));

endmodule

// File: data_mem.sv
`timescale 1ns/1ps

module data_mem (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                mem_en,
    input  logic                                mem_we,
    input  logic [lk_cfg_pkg::dm_addr_bits-1:0] mem_addr,
    input  logic [15:0]                         mem_wdata,
    input  logic                                dbg_sel,
    output logic [15:0]                         rdata,
    output logic [15:0]                         dbg_data
);
    import lk_cfg_pkg::*;

    logic [15:0] mem [dm_words];

    // read first, a write returns the old word
    always_ff @(posedge clk) begin
        if (mem_en) begin
            rdata <= mem[mem_addr];
            if (mem_we)
                mem[mem_addr] <= mem_wdata;
        end
    end

    // rdata is the debug word in the cycle after a debug grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dbg_data <= '0;
        else if (dbg_sel)
            dbg_data <= rdata;
    end

endmodule

// File: event_counters.sv
`timescale 1ns/1ps

module event_counters (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            run_en,
    input  logic                            retire,
    input  logic                            is_jump,
    input  logic                            is_branch,
    input  logic                            branched,
    input  logic                            is_nop,
    output logic [lk_cfg_pkg::cnt_bits-1:0] cnt_cycle,
    output logic [lk_cfg_pkg::cnt_bits-1:0] cnt_jump,
    output logic [lk_cfg_pkg::cnt_bits-1:0] cnt_branch,
    output logic [lk_cfg_pkg::cnt_bits-1:0] cnt_branched,
    output logic [lk_cfg_pkg::cnt_bits-1:0] cnt_nop
);
    import lk_cfg_pkg::*;

    logic [4:0]          inc;
    logic [cnt_bits-1:0] cnt [5];

    assign inc[0] = run_en; // the cycle counter sees every running clock
    assign inc[1] = run_en && retire && is_jump;
    assign inc[2] = run_en && retire && is_branch;
    assign inc[3] = run_en && retire && branched;
    assign inc[4] = run_en && retire && is_nop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 5; i++)
                cnt[i] <= '0;
        end else begin
            for (int i = 0; i < 5; i++)
                if (inc[i])
                    cnt[i] <= cnt[i] + 1'b1; // wraps silently
        end
    end

    assign cnt_cycle    = cnt[0];
    assign cnt_jump     = cnt[1];
    assign cnt_branch   = cnt[2];
    assign cnt_branched = cnt[3];
    assign cnt_nop      = cnt[4];

endmodule

// File: seg_display.sv
`timescale 1ns/1ps

module seg_display (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] data,
    output logic [7:0]  seg_n,
    output logic [7:0]  an_n
);
    import lk_cfg_pkg::*;

    logic [$clog2(scan_cnt_max)-1:0] scan_cnt;
    logic [2:0]                      digit;

    // segments a..g in bits 0..6, active high here
    function automatic logic [6:0] hex_seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'h3f;
            4'h1: return 7'h06;
            4'h2: return 7'h5b;
            4'h3: return 7'h4f;
            4'h4: return 7'h66;
            4'h5: return 7'h6d;
            4'h6: return 7'h7d;
            4'h7: return 7'h07;
            4'h8: return 7'h7f;
            4'h9: return 7'h6f;
            4'ha: return 7'h77;
            4'hb: return 7'h7c;
            4'hc: return 7'h39;
            4'hd: return 7'h5e;
            4'he: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            digit    <= '0;
            seg_n    <= 8'hff; // everything dark until the first scan step
            an_n     <= 8'hff;
        end else if (scan_cnt == scan_cnt_max - 1) begin
            scan_cnt <= '0;
            digit    <= digit + 1'b1;
            an_n     <= ~(8'h01 << digit);
            seg_n    <= {1'b1, ~hex_seg(data[digit*4 +: 4])}; // dp stays off
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

endmodule

// File: lk_top.sv
`timescale 1ns/1ps

module lk_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        resume,
    input  logic [15:0] swt,
    output logic [7:0]  seg_n,
    output logic [7:0]  an_n
);
    import lk_cfg_pkg::*;
    import lk_isa_pkg::*;

    logic                    run_en;
    logic                    halt;
    logic                    retire;
    logic                    is_jump;
    logic                    is_branch;
    logic                    branched;
    logic                    is_nop;
    logic                    core_req;
    logic                    core_we;
    logic                    core_gnt;
    logic [dm_addr_bits-1:0] core_addr;
    logic [word_bits-1:0]    core_wdata;
    logic [word_bits-1:0]    core_rdata;
    logic [word_bits-1:0]    pc;
    logic [word_bits-1:0]    core_display;
    logic                    mem_en;
    logic                    mem_we;
    logic [dm_addr_bits-1:0] mem_addr;
    logic [word_bits-1:0]    mem_wdata;
    logic                    dbg_sel;
    logic [word_bits-1:0]    dbg_data;
    logic                    dbg_req;
    logic [dm_addr_bits-1:0] dbg_addr;
    logic [cnt_bits-1:0]     cnt_cycle;
    logic [cnt_bits-1:0]     cnt_jump;
    logic [cnt_bits-1:0]     cnt_branch;
    logic [cnt_bits-1:0]     cnt_branched;
    logic [cnt_bits-1:0]     cnt_nop;
    logic [2:0]              disp_sel;
    logic [31:0]             disp_data;

    assign disp_sel = swt[2:0];
    assign dbg_addr = swt[15:15-dm_addr_bits+1];
    assign dbg_req  = 1'b1; // debug reader polls in every free cycle

    // ==========================================================
    // display source selection
    // ==========================================================
    always_comb begin
        case (disp_sel)
            disp_core:    disp_data = {16'd0, core_display};
            disp_cnt_cyc: disp_data = cnt_cycle;
            disp_cnt_jmp: disp_data = cnt_jump;
            disp_cnt_bch: disp_data = cnt_branch;
            disp_cnt_bed: disp_data = cnt_branched;
            disp_cnt_nop: disp_data = cnt_nop;
            disp_pc:      disp_data = {16'd0, pc};
            default:      disp_data = {16'd0, dbg_data};
        endcase
    end

    // ==========================================================
    // instances
    // ==========================================================
    run_control v_run (
        .clk(clk), .rst_n(rst_n), .halt(halt), .resume(resume), .run_en(run_en)
    );

    step_core v_core (
        .clk(clk), .rst_n(rst_n), .run_en(run_en), .core_gnt(core_gnt),
        .core_rdata(core_rdata), .core_req(core_req), .core_we(core_we),
        .core_addr(core_addr), .core_wdata(core_wdata), .halt(halt),
        .retire(retire), .is_jump(is_jump), .is_branch(is_branch),
        .branched(branched), .is_nop(is_nop), .pc(pc), .display(core_display)
    );

    dm_arbiter v_arb (
        .clk(clk), .rst_n(rst_n), .core_req(core_req), .core_we(core_we),
        .core_addr(core_addr), .core_wdata(core_wdata), .dbg_req(dbg_req),
        .dbg_addr(dbg_addr), .core_gnt(core_gnt), .dbg_gnt(),
        .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .dbg_sel(dbg_sel)
    );

    data_mem v_dm (
        .clk(clk), .rst_n(rst_n), .mem_en(mem_en), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .dbg_sel(dbg_sel),
        .rdata(core_rdata), .dbg_data(dbg_data)
    );

    event_counters v_cnt (
        .clk(clk), .rst_n(rst_n), .run_en(run_en), .retire(retire),
        .is_jump(is_jump), .is_branch(is_branch), .branched(branched),
        .is_nop(is_nop), .cnt_cycle(cnt_cycle), .cnt_jump(cnt_jump),
        .cnt_branch(cnt_branch), .cnt_branched(cnt_branched), .cnt_nop(cnt_nop)
    );

    seg_display v_disp (
        .clk(clk), .rst_n(rst_n), .data(disp_data), .seg_n(seg_n), .an_n(an_n)
    );

endmodule

// File: tb_lk_top.sv
`timescale 1ns/1ps

module tb_lk_top;
    import lk_cfg_pkg::*;
    import lk_isa_pkg::*;

    localparam int prog_cycles = 40; // both program sections together run for 28 cycles

    logic        clk;
    logic        rst_n;
    logic        resume;
    logic [15:0] swt;
    logic [7:0]  seg_n;
    logic [7:0]  an_n;

    // stimulus table with one entry per row in each queue
    string       row_name[$];
    logic [15:0] row_swt[$];
    bit          row_resume[$];
    logic [31:0] row_exp[$];

    int cycles = 0;
    int limit = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int seed;

    lk_top UUT (
        .clk(clk), .rst_n(rst_n), .resume(resume), .swt(swt), .seg_n(seg_n), .an_n(an_n)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: the tests did not finish within %0d cycles", limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ============================================================
    // helpers
    // ============================================================
    function automatic logic [15:0] sw_val(input logic [2:0] sel,
                                           input logic [dm_addr_bits-1:0] addr);
        logic [15:0] v;
        v = '0;
        v[15 -: dm_addr_bits] = addr;
        v[2:0] = sel;
        return v;
    endfunction

    // returns {legal, nibble} with segments a..g on bits 0..6
    function automatic logic [4:0] decode_seg(input logic [7:0] pattern);
        logic [6:0] lit;
        logic [4:0] r;
        lit = ~pattern[6:0];
        case (lit)
            7'h3f: r = 5'h10;
            7'h06: r = 5'h11;
            7'h5b: r = 5'h12;
            7'h4f: r = 5'h13;
            7'h66: r = 5'h14;
            7'h6d: r = 5'h15;
            7'h7d: r = 5'h16;
            7'h07: r = 5'h17;
            7'h7f: r = 5'h18;
            7'h6f: r = 5'h19;
            7'h77: r = 5'h1a;
            7'h7c: r = 5'h1b;
            7'h39: r = 5'h1c;
            7'h5e: r = 5'h1d;
            7'h79: r = 5'h1e;
            7'h71: r = 5'h1f;
            default: r = 5'h00;
        endcase
        if (pattern[7] !== 1'b1)
            r[4] = 1'b0; // a lit decimal point is never a hex digit
        return r;
    endfunction

    task automatic add_row(input string name, input logic [15:0] sw, input bit res,
                           input logic [31:0] expv);
        row_name.push_back(name);
        row_swt.push_back(sw);
        row_resume.push_back(res);
        row_exp.push_back(expv);
    endtask

    task automatic wait_run(input bit level);
        @(negedge clk);
        while (UUT.run_en !== level)
            @(negedge clk);
    endtask

    task automatic pulse_resume();
        @(posedge clk);
        resume <= 1'b1;
        @(posedge clk);
        resume <= 1'b0;
        wait_run(1'b1);
    endtask

    task automatic set_switches(input logic [15:0] value);
        @(posedge clk);
        swt <= value;
        repeat (3) @(posedge clk); // an idle-core debug read lands in dbg_data two cycles on
    endtask

    // collects one full scan that starts at a fresh digit 0
    task automatic read_display(output logic [31:0] value, output bit legal);
        logic [4:0] dec;
        value = '0;
        legal = 1'b1;
        @(negedge clk);
        while (an_n == 8'hfe)
            @(negedge clk);
        for (int d = 0; d < 8; d++) begin
            while (an_n != ~(8'h01 << d))
                @(negedge clk);
            dec = decode_seg(seg_n);
            if (!dec[4]) begin
                $display("illegal segment pattern %b on digit %0d", seg_n, d);
                legal = 1'b0;
            end
            value[d*4 +: 4] = dec[3:0];
        end
    endtask

    task automatic run_row(input int i, input bit shuffled);
        logic [31:0] got;
        bit          legal;
        string       name;
        name = shuffled ? {"t5 ", row_name[i]} : row_name[i];
        if (row_resume[i] && !shuffled)
            pulse_resume();
        wait_run(1'b0);
        set_switches(row_swt[i]);
        read_display(got, legal);
        if (got !== row_exp[i])
            $display("CHECK FAILED seg_n decoded value in %s: got 0x%08h, expected 0x%08h",
                     name, got, row_exp[i]);
        if (got === row_exp[i] && legal) begin
            pass_cnt++;
            $display("PASS %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL %s", name);
        end
    endtask

    // ============================================================
    // table and run
    // ============================================================
    initial begin
        int order[$];
        int first_b;
        int n_runs;
        int j;
        int tmp;
        rst_n  = 1'b0;
        resume = 1'b0;
        swt    = '0;
        seed   = 57930;

        // the loop sums 3+2+1 into r3 and r4 doubles it before the first HALT at 13
        add_row("t1 core display", sw_val(disp_core, 0), 1'b0, 32'h0000_000c);
        add_row("t2 cycle count", sw_val(disp_cnt_cyc, 0), 1'b0, 32'd22); // 21 retired and one LD
        add_row("t2 jump count", sw_val(disp_cnt_jmp, 0), 1'b0, 32'd2);
        add_row("t2 branch count", sw_val(disp_cnt_bch, 0), 1'b0, 32'd3);
        add_row("t2 taken branches", sw_val(disp_cnt_bed, 0), 1'b0, 32'd1);
        add_row("t2 nop count", sw_val(disp_cnt_nop, 0), 1'b0, 32'd1);
        add_row("t3 mem 0x05", sw_val(disp_dm_dbg, 6'h05), 1'b0, 32'd6);
        add_row("t3 mem 0x21", sw_val(disp_dm_dbg, 6'h21), 1'b0, 32'd12);
        first_b = row_name.size();
        // the second section retires 14..19 and its HALT at 19 steps the pc to 20
        add_row("t4 pc after second halt", sw_val(disp_pc, 0), 1'b1, 32'd20);
        add_row("t4 core display", sw_val(disp_core, 0), 1'b0, 32'h0000_005a);
        add_row("t4 cycle count", sw_val(disp_cnt_cyc, 0), 1'b0, 32'd28);
        add_row("t4 jump count", sw_val(disp_cnt_jmp, 0), 1'b0, 32'd2);
        add_row("t4 branch count", sw_val(disp_cnt_bch, 0), 1'b0, 32'd4);
        add_row("t4 taken branches", sw_val(disp_cnt_bed, 0), 1'b0, 32'd1);
        add_row("t4 nop count", sw_val(disp_cnt_nop, 0), 1'b0, 32'd2);
        add_row("t4 mem 0x3f", sw_val(disp_dm_dbg, 6'h3f), 1'b0, 32'h0000_005a);
        add_row("t4 mem 0x21", sw_val(disp_dm_dbg, 6'h21), 1'b0, 32'd12);

        // a read can wait up to two scans for digit 0 before its own scan
        n_runs = row_name.size() + (row_name.size() - first_b);
        limit  = 3 * n_runs * 8 * scan_cnt_max + prog_cycles + 100;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < row_name.size(); i++)
            run_row(i, 1'b0);

        for (int i = first_b; i < row_name.size(); i++)
            order.push_back(i);
        for (int k = order.size() - 1; k > 0; k--) begin
            j = $unsigned($random(seed)) % (k + 1);
            tmp = order[k];
            order[k] = order[j];
            order[j] = tmp;
        end
        foreach (order[k])
            run_row(order[k], 1'b1);

        $display("tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt,
                 fail_cnt);
        if (fail_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: prog.hex
// one instruction per line: opcode[15:12] rd[11:9] rs[8:6] or imm[7:0]
1203 // 00 ldi r1, 3
14FF // 01 ldi r2, -1
1600 // 02 ldi r3, 0
2640 // 03 add r3, r1
2280 // 04 add r1, r2
5201 // 05 beqz r1, +1
6003 // 06 jmp 3
4605 // 07 st r3, 0x05
3805 // 08 ld r4, 0x05
2900 // 09 add r4, r4
4821 // 0a st r4, 0x21
0000 // 0b nop
7800 // 0c disp r4
8000 // 0d halt
0000 // 0e nop
1A5A // 0f ldi r5, 0x5a
4A3F // 10 st r5, 0x3f
5A7F // 11 beqz r5, +0x7f
7A00 // 12 disp r5
8000 // 13 halt

// File: sim.f
lk_cfg_pkg.sv
lk_isa_pkg.sv
run_control.sv
step_core.sv
dm_arbiter.sv
data_mem.sv
event_counters.sv
seg_display.sv
lk_top.sv
tb_lk_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lk_top -f sim.f -o sim_lk \
    && ./obj_dir/sim_lk | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "Result: FAILED" sim.log && { echo "simulation reported failures"; exit 1; }
echo "simulation finished without failures"
exit 0
